//--- Makefile
# Verilator build and run of the stream realigner testbench.

VERILATOR ?= verilator
TOP       ?= arm_realigner_tb
FILELIST  ?= arm_realigner.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
DATA    := test/realign_tests.txt
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- arm_realigner.f
logic/frame_fmt_pkg.sv
logic/realign_ctl_pkg.sv
logic/beat_decode.sv
logic/realign_execute.sv
logic/beat_result.sv
logic/arm_realigner.sv
test/stream_checker.sv
test/arm_realigner_tb.sv

//--- logic/arm_realigner.sv
/* Stream realigner that puts six zero bytes in front of each frame.
   Every frame needs at least two input beats. Frames are not checked for errors. */
`timescale 1ns/1ps
`default_nettype none

module arm_realigner
  import frame_fmt_pkg::*;
  import realign_ctl_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,
  input  logic [beat_width-1:0] in_data,
  input  logic [user_width-1:0] in_user,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [beat_width-1:0] out_data,
  output logic [user_width-1:0] out_user,
  output logic                  out_last,
  output logic                  out_valid,
  input  logic                  out_ready
);

  beat_word_u             reg_word;
  logic [count_width-1:0] reg_count;
  logic                   reg_last;
  logic                   reg_valid;
  logic                   spill;
  realign_state_e         state;
  logic [tail_width-1:0]  hold_tail;
  logic [count_width-1:0] hold_count;
  logic                   out_fire;
  logic                   accept;

  // ----------------------------------------
  // Stages
  // ----------------------------------------
  beat_decode decode0 (
    .clk, .arst_n, .clear,
    .in_data, .in_user, .in_last, .in_valid, .in_ready, .accept,
    .reg_word, .reg_count, .reg_last, .reg_valid, .spill
  );

  realign_execute execute0 (
    .clk, .arst_n, .clear,
    .reg_word, .reg_count, .reg_last, .reg_valid, .spill, .out_fire,
    .state, .hold_tail, .hold_count
  );

  beat_result result0 (
    .clk, .arst_n, .clear,
    .state, .reg_word, .reg_count, .reg_last, .reg_valid, .spill,
    .hold_tail, .hold_count, .in_valid, .out_ready,
    .out_data, .out_user, .out_last, .out_valid, .out_fire, .accept, .in_ready
  );

endmodule

`default_nettype wire

//--- logic/beat_decode.sv
/* Input register of the realigner. The count comes from the low three user bits.
   Only the last beat of a frame may carry a nonzero count. */
`timescale 1ns/1ps
`default_nettype none

module beat_decode
  import frame_fmt_pkg::*;
  import realign_ctl_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   clear,
  input  logic [beat_width-1:0]  in_data,
  input  logic [user_width-1:0]  in_user,
  input  logic                   in_last,
  input  logic                   in_valid,
  input  logic                   in_ready,
  input  logic                   accept,
  output beat_word_u             reg_word,
  output logic [count_width-1:0] reg_count,
  output logic                   reg_last,
  output logic                   reg_valid,
  output logic                   spill
);

  // ----------------------------------------
  // Control register
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_valid <= 1'b0;
      reg_last  <= 1'b0;
      reg_count <= count_full;
    end else if (clear) begin
      reg_valid <= 1'b0;
      reg_last  <= 1'b0;
      reg_count <= count_full;
    end else begin
      // While ready, the old beat leaves and the new one (if any) takes its place.
      if (in_ready) begin
        reg_valid <= in_valid;
      end
      if (accept) begin
        reg_last  <= in_last;
        reg_count <= in_user[count_width-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reg_word.raw <= in_data;
    end
  end

  // Tail no longer fits next to the header gap.
  assign spill = (reg_count == count_full) ||
                 (reg_count > count_width'(lead_bytes));

  // Partial counts belong on the last beat only.
  a_count_on_last : assert property (@(posedge clk) disable iff (!arst_n)
    reg_valid && (reg_count != count_full) |-> reg_last);

endmodule

`default_nettype wire

//--- logic/beat_result.sv
/* Output mux of the realigner. The output count is the input count plus six,
   modulo eight. The input is stalled while the closing beat goes out. */
`timescale 1ns/1ps
`default_nettype none

module beat_result
  import frame_fmt_pkg::*;
  import realign_ctl_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   clear,
  input  realign_state_e         state,
  input  beat_word_u             reg_word,
  input  logic [count_width-1:0] reg_count,
  input  logic                   reg_last,
  input  logic                   reg_valid,
  input  logic                   spill,
  input  logic [tail_width-1:0]  hold_tail,
  input  logic [count_width-1:0] hold_count,
  input  logic                   in_valid,
  input  logic                   out_ready,
  output logic [beat_width-1:0]  out_data,
  output logic [user_width-1:0]  out_user,
  output logic                   out_last,
  output logic                   out_valid,
  output logic                   out_fire,
  output logic                   accept,
  output logic                   in_ready
);

  logic [count_width-1:0] out_count;

  always_comb begin
    out_data  = '0;
    out_valid = 1'b0;
    out_last  = 1'b0;
    out_count = count_full;
    in_ready  = out_ready;
    case (state)
      idle: begin
        out_data  = {{tail_width{1'b0}}, reg_word.lanes.lead};   // Header gap first.
        out_valid = reg_valid;
      end
      in_frame: begin
        out_data  = {hold_tail, reg_word.lanes.lead};
        out_valid = reg_valid;
        out_last  = reg_valid && reg_last && !spill;
        if (out_last) begin
          out_count = reg_count + count_width'(tail_bytes);
        end
      end
      extra_beat: begin
        out_data  = {hold_tail, {lead_width{1'b0}}};
        out_valid = 1'b1;
        out_last  = 1'b1;
        out_count = hold_count + count_width'(tail_bytes);
        in_ready  = 1'b0;                                       // Stall input.
      end
      default: begin
        in_ready = 1'b0;
      end
    endcase
  end

  assign out_user = {{(user_width - count_width){1'b0}}, out_count};
  assign out_fire = out_valid && out_ready;
  assign accept   = in_valid && in_ready;

  // A stalled output beat holds until it is taken.
  a_out_stable : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready && !clear |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- logic/frame_fmt_pkg.sv
/* Beat format of the processor stream. Bytes are packed most significant first.
   A last-beat count of zero stands for a full beat of eight bytes. */
`default_nettype none

package frame_fmt_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int beat_width  = 64;
  localparam int user_width  = 4;
  localparam int count_width = 3;                  // Low user bits, the byte count.

  // Lane split of one beat.
  localparam int lead_width  = 16;                 // Bytes 0 and 1.
  localparam int tail_width  = beat_width - lead_width;

  // ----------------------------------------
  // Byte-count encoding
  // ----------------------------------------
  localparam logic [count_width-1:0] count_full = '0;

  // One beat, seen as a raw word or as its lead and tail lanes.
  typedef union packed {
    logic [beat_width-1:0] raw;
    struct packed {
      logic [lead_width-1:0] lead;                 // Goes out with the previous tail.
      logic [tail_width-1:0] tail;                 // Held for the next output beat.
    } lanes;
  } beat_word_u;

endpackage

`default_nettype wire

//--- logic/realign_ctl_pkg.sv
/* Control definitions of the realigner. The header gap is fixed at six bytes,
   so the payload moves by one 16-bit lane. */
`default_nettype none

package realign_ctl_pkg;

  // Lane offset in bytes.
  localparam int lead_bytes = 2;                   // Taken from each new beat.
  localparam int tail_bytes = 6;                   // Held back, also the header gap.

  typedef enum logic [1:0] {
    idle       = 2'b00,                            // Waiting for a first beat.
    in_frame   = 2'b01,
    extra_beat = 2'b10                             // Closing beat with the shifted tail.
  } realign_state_e;

endpackage

`default_nettype wire

//--- logic/realign_execute.sv
/* Frame state machine of the realigner. Frames must have at least two beats,
   since the first beat of a frame is never treated as the last. */
`timescale 1ns/1ps
`default_nettype none

module realign_execute
  import frame_fmt_pkg::*;
  import realign_ctl_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   clear,
  input  beat_word_u             reg_word,
  input  logic [count_width-1:0] reg_count,
  input  logic                   reg_last,
  input  logic                   reg_valid,
  input  logic                   spill,
  input  logic                   out_fire,
  output realign_state_e         state,
  output logic [tail_width-1:0]  hold_tail,
  output logic [count_width-1:0] hold_count
);

  realign_state_e state_next;
  logic           beat_taken;

  // The registered beat leaves on this edge. The extra beat comes from the hold register.
  assign beat_taken = out_fire && reg_valid && (state != extra_beat);

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (beat_taken) begin
          state_next = in_frame;
        end
      end
      in_frame: begin
        if (beat_taken && reg_last) begin
          state_next = spill ? extra_beat : idle;
        end
      end
      extra_beat: begin
        if (out_fire) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else if (clear) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------------------
  // Hold register
  // ----------------------------------------
  // Tail lane of the last beat sent, and its count for the closing beat.
  always_ff @(posedge clk) begin
    if (beat_taken) begin
      hold_tail  <= reg_word.lanes.tail;
      hold_count <= reg_count;
    end
  end

  // The first beat taken in a frame is never its last.
  a_first_not_last : assert property (@(posedge clk) disable iff (!arst_n)
    (state == idle) && beat_taken |-> !reg_last);

endmodule

`default_nettype wire

//--- test/arm_realigner_tb.sv
/* Testbench of the stream realigner. Frames come from test/realign_tests.txt and
   must be at least nine bytes long. Runs from the project root. */
`timescale 1ns/1ps
`default_nettype none

module arm_realigner_tb;

  localparam int max_tests    = 64;
  localparam int reset_cycles = 16;

  logic        clk;
  logic        arst_n;
  logic        clear;
  logic [63:0] in_data;
  logic [3:0]  in_user;
  logic        in_last;
  logic        in_valid;
  logic        in_ready;
  logic [63:0] out_data;
  logic [3:0]  out_user;
  logic        out_last;
  logic        out_valid;
  logic        out_ready = 1'b0;

  logic [127:0] test_name [max_tests];
  int           test_len [max_tests];
  logic [7:0]   test_first [max_tests];
  int           ntests;
  int           limit;
  int           cycles;
  int           tb_errors;
  integer       seed = 77;
  logic [31:0]  rnd;
  logic         gap_roll = 1'b0;
  logic         run_started;

  int           exp_seq;
  logic [127:0] exp_name;
  int           exp_len;
  logic [7:0]   exp_first;
  int           mismatches;
  int           other_errors;
  int           frames_done;

  arm_realigner dut0 (
    .clk, .arst_n, .clear, .in_data, .in_user, .in_last, .in_valid, .in_ready,
    .out_data, .out_user, .out_last, .out_valid, .out_ready
  );

  stream_checker chk0 (
    .clk, .arst_n, .clear, .in_valid, .in_ready,
    .out_data, .out_user, .out_last, .out_valid, .out_ready,
    .exp_seq, .exp_name, .exp_len, .exp_first,
    .mismatches, .other_errors, .frames_done
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // One draw per cycle for back-pressure and input gaps.
  always @(negedge clk) begin
    rnd = $random(seed);
    out_ready <= (rnd[1:0] != 2'b00);
    gap_roll  <= (rnd[3:2] == 2'b00);
  end

  // ----------------------------------------
  // Tasks
  // ----------------------------------------
  task automatic load_tests();
    int           fd;
    int           code;
    int           total_bytes;
    string        line;
    logic [127:0] name_v;
    int           len_v;
    logic [7:0]   first_v;
    ntests      = 0;
    total_bytes = 0;
    fd = $fopen("test/realign_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/realign_tests.txt");
      return;
    end
    while (!$feof(fd) && ntests < max_tests) begin
      code = $fgets(line, fd);
      if (code > 0 && $sscanf(line, "%s %d %h", name_v, len_v, first_v) == 3) begin
        if (len_v < 9) begin
          tb_errors++;
          $display("Frame %s is shorter than two beats and was skipped", name_v);
        end else begin
          test_name[ntests]  = name_v;
          test_len[ntests]   = len_v;
          test_first[ntests] = first_v;
          total_bytes        = total_bytes + len_v;
          ntests++;
        end
      end
    end
    $fclose(fd);
    limit = (total_bytes / 8 + 2 * ntests) * 4;
  endtask

  task automatic send_frame(input int t);
    int          nbeats;
    int          b;
    int          k;
    logic [63:0] word;
    logic        taken;
    nbeats    = (test_len[t] + 7) / 8;
    exp_name  = test_name[t];
    exp_len   = test_len[t];
    exp_first = test_first[t];
    exp_seq   = exp_seq + 1;                       // Announces the frame to the checker.
    for (b = 0; b < nbeats; b++) begin
      while (gap_roll) begin
        in_valid = 1'b0;
        @(negedge clk);
      end
      for (k = 0; k < 8; k++) begin
        word[63 - 8*k -: 8] = (b * 8 + k < test_len[t]) ?
                              test_first[t] + 8'(b * 8 + k) : 8'h00;
      end
      in_data  = word;
      in_last  = (b == nbeats - 1);
      in_user  = in_last ? 4'(test_len[t] % 8) : 4'd0;
      in_valid = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
        @(posedge clk);
        taken = in_ready;
      end
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic clear_between_frames();
    while (frames_done != exp_seq) begin
      @(negedge clk);
    end
    // A stray beat offered with the clear must not come out.
    in_data  = {8{8'hc5}};
    in_user  = 4'd0;
    in_last  = 1'b0;
    in_valid = 1'b1;
    clear    = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    clear    = 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    int total;
    total = mismatches + other_errors + tb_errors + (timed_out ? 1 : 0);
    $display("Errors: %0d mismatches, %0d other checker, %0d testbench, timeout %0d",
             mismatches, other_errors, tb_errors, timed_out);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    arst_n      = 1'b0;
    clear       = 1'b0;
    in_data     = '0;
    in_user     = '0;
    in_last     = 1'b0;
    in_valid    = 1'b0;
    run_started = 1'b0;
    tb_errors   = 0;
    exp_seq     = 0;
    exp_name    = '0;
    exp_len     = 0;
    exp_first   = '0;
    load_tests();
    if (ntests == 0) begin
      tb_errors++;
      $display("No tests were loaded");
      finish_run(1'b0);
    end else begin
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n      = 1'b1;
      run_started = 1'b1;
      for (int t = 0; t < ntests; t++) begin
        if (t > 0 && t % 7 == 0) begin
          clear_between_frames();
        end
        send_frame(t);
      end
      while (frames_done != ntests) begin
        @(negedge clk);
      end
      repeat (4) @(negedge clk);                   // Catch stray beats.
      finish_run(1'b0);
    end
  end

  initial begin
    wait (run_started);
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d frames checked",
             cycles, frames_done, ntests);
    finish_run(1'b1);
  end

endmodule

`default_nettype wire

//--- test/realign_tests.txt
# name  length  first_byte
# length in bytes, at least 9, first byte in hex, bytes count up modulo 256
short_9     9    00
short_10    10   10
short_11    11   20
short_12    12   fe
short_13    13   7f
short_14    14   80
short_15    15   ff
short_16    16   01
mid_17      17   a5
mid_18      18   5a
mid_19      19   33
mid_20      20   c0
mid_21      21   f8
mid_22      22   0f
mid_23      23   44
mid_24      24   99
long_40     40   12
long_41     41   e0
long_42     42   f0
long_43     43   3c
long_60     60   c3
long_63     63   71
long_64     64   08
long_100    100  fa
long_129    129  6e
long_201    201  b7
long_250    250  55
long_255    255  20

//--- test/stream_checker.sv
/* Output checker of the realigner testbench. Frames are expected in the order that
   the testbench announces them on exp_seq. */
`timescale 1ns/1ps
`default_nettype none

module stream_checker (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clear,
  input  logic         in_valid,
  input  logic         in_ready,
  input  logic [63:0]  out_data,
  input  logic [3:0]   out_user,
  input  logic         out_last,
  input  logic         out_valid,
  input  logic         out_ready,
  input  int           exp_seq,
  input  logic [127:0] exp_name,
  input  int           exp_len,
  input  logic [7:0]   exp_first,
  output int           mismatches,
  output int           other_errors,
  output int           frames_done
);

  localparam int header_bytes = 6;                 // Zero bytes in front of each frame.

  logic [127:0] q_name[$];
  int           q_len[$];
  logic [7:0]   q_first[$];
  int           seen_seq;
  int           beat_idx;
  logic         quiet;                             // No input beat taken since reset or clear.

  function automatic logic [7:0] frame_byte(input int pos, input logic [7:0] first);
    if (pos < header_bytes) begin
      return 8'h00;
    end
    return first + 8'(pos - header_bytes);
  endfunction

  // ----------------------------------------
  // One output beat against the frame in front
  // ----------------------------------------
  task automatic check_beat();
    int          total;
    int          nbeats;
    int          pos;
    int          j;
    logic [63:0] exp_word;
    logic [63:0] mask;
    logic        is_last;
    logic        spill_beat;
    total      = q_len[0] + header_bytes;
    nbeats     = (total + 7) / 8;
    spill_beat = ((total + 7) / 8) > ((q_len[0] + 7) / 8);
    exp_word   = '0;
    mask       = '0;
    for (j = 0; j < 8; j++) begin
      pos = beat_idx * 8 + j;
      if (pos < total) begin
        exp_word[63 - 8*j -: 8] = frame_byte(pos, q_first[0]);
        mask[63 - 8*j -: 8]     = 8'hff;
      end
    end
    is_last = (beat_idx == nbeats - 1);
    if ((out_data & mask) !== exp_word) begin
      mismatches++;
      $display("MISMATCH %s beat %0d data expected %h actual %h",
               q_name[0], beat_idx, exp_word, out_data & mask);
    end
    if (out_last !== is_last) begin
      mismatches++;
      $display("MISMATCH %s beat %0d last expected %b actual %b",
               q_name[0], beat_idx, is_last, out_last);
    end
    if (is_last) begin
      if (out_user !== 4'(total % 8)) begin
        mismatches++;
        $display("MISMATCH %s byte count expected %0d actual %0d",
                 q_name[0], total % 8, out_user);
      end
      if (spill_beat && in_ready !== 1'b0) begin
        other_errors++;
        $display("Input was ready during the closing beat of %s", q_name[0]);
      end
      q_name.delete(0);
      q_len.delete(0);
      q_first.delete(0);
      frames_done++;
      beat_idx = 0;
    end else begin
      beat_idx++;
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q_name.delete();
      q_len.delete();
      q_first.delete();
      seen_seq     = exp_seq;
      beat_idx     = 0;
      quiet        = 1'b1;
      mismatches   = 0;
      other_errors = 0;
      frames_done  = 0;
    end else begin
      if (exp_seq != seen_seq) begin
        q_name.push_back(exp_name);
        q_len.push_back(exp_len);
        q_first.push_back(exp_first);
        seen_seq = exp_seq;
      end
      if (quiet && (out_valid || out_last)) begin
        other_errors++;
        $display("Output active after reset or clear before any input beat was taken");
      end
      if (out_valid && out_ready) begin
        if (q_len.size() == 0) begin
          other_errors++;
          $display("Output beat %h with no frame outstanding", out_data);
        end else begin
          check_beat();
        end
      end
      if (clear) begin
        quiet = 1'b1;
      end else if (in_valid && in_ready) begin
        quiet = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
